//--- source/noc_pkg.sv
// Mesh widths, coordinate and destination types, direction encoding, system address map
`default_nettype none

package noc_pkg;

  // Bits for one mesh coordinate, 4x4 mesh
  localparam int unsigned MeshDimW = 2;
  // Endpoint number covers both coordinates
  localparam int unsigned EpIdW = 2 * MeshDimW;

  typedef logic [MeshDimW-1:0] coord_t;

  // y in the upper half, x in the lower half
  typedef struct packed {
    coord_t y;
    coord_t x;
  } xy_id_t;

  // Same word seen as a flat endpoint number or as a coordinate pair
  // Endpoint n sits at x = n mod 4, y = n div 4
  typedef union packed {
    logic [EpIdW-1:0] flat;
    xy_id_t           xy;
  } dst_id_u;

  typedef logic [31:0] addr_t;

  // Output port of the router
  typedef enum logic [2:0] {
    DirLocal = 3'd0,
    DirEast  = 3'd1,
    DirWest  = 3'd2,
    DirNorth = 3'd3,
    DirSouth = 3'd4
  } route_dir_e;

  // One map rule, start inclusive, end exclusive
  // Endpoint index padded up to a full byte
  typedef struct packed {
    addr_t            start_addr;
    addr_t            end_addr;
    logic [3:0]       rsvd;
    logic [EpIdW-1:0] idx;
  } sam_rule_t;

  localparam int unsigned NumSamRules = 4;

  // Fixed system address map, searched in rule order
  localparam sam_rule_t [NumSamRules-1:0] SamMap = '{
    0: '{start_addr: 32'h0000_0000, end_addr: 32'h1000_0000, rsvd: 4'h0, idx: 4'd5},
    1: '{start_addr: 32'h1000_0000, end_addr: 32'h2000_0000, rsvd: 4'h0, idx: 4'd10},
    // Small 1 MiB window
    2: '{start_addr: 32'h4000_0000, end_addr: 32'h4010_0000, rsvd: 4'h0, idx: 4'd0},
    3: '{start_addr: 32'h8000_0000, end_addr: 32'hC000_0000, rsvd: 4'h0, idx: 4'd15}
  };

  // Miss counter width, saturates at all ones
  localparam int unsigned ErrCntW = 8;

endpackage

`default_nettype wire

//--- source/noc_stage_if.sv
// Stage interfaces noc_dec_if (decode to execute) and noc_route_if (execute to result)
`timescale 1ns/100ps
`default_nettype none

// Decode result, valid is a one-cycle strobe
interface noc_dec_if import noc_pkg::*; ();
  logic    valid;
  addr_t   addr;
  dst_id_u dst_id;
  // Address matched no map rule
  logic    miss;

  modport src (output valid, addr, dst_id, miss);
  modport dst (input valid, addr, dst_id, miss);
endinterface

// Routed request, fields meaningful only while valid is high
interface noc_route_if import noc_pkg::*; ();
  logic       valid;
  addr_t      addr;
  dst_id_u    dst_id;
  route_dir_e dir;
  logic       miss;

  modport src (output valid, addr, dst_id, dir, miss);
  modport dst (input valid, addr, dst_id, dir, miss);
endinterface

`default_nettype wire

//--- source/addr_translate.sv
// Decode stage addr_translate: address to destination by map search or bit offsets
`timescale 1ns/100ps
`default_nettype none

module addr_translate import noc_pkg::*; #(
  // Search SamMap when set, slice coordinates from the address when clear
  parameter bit UseIdTable  = 1'b1,
  // Lowest bit of the x coordinate in the address
  parameter int XAddrOffset = 12,
  // Lowest bit of the y coordinate in the address
  parameter int YAddrOffset = 14
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      valid_i,
  input  addr_t     addr_i,
  noc_dec_if.src    out_o
);

  // Combinational decode result
  dst_id_u dec_dst;
  logic    dec_miss;

  // Stage registers
  logic    valid_q;
  logic    miss_q;
  addr_t   addr_q;
  dst_id_u dst_q;

  if (UseIdTable) begin : gen_sam_search
    always_comb begin
      // Default is a miss with endpoint 0
      dec_dst.flat = '0;
      dec_miss     = 1'b1;
      for (int unsigned i = 0; i < NumSamRules; i++) begin
        // Only the first matching rule counts
        if (dec_miss && (addr_i >= SamMap[i].start_addr) &&
            (addr_i < SamMap[i].end_addr)) begin
          dec_dst.flat = SamMap[i].idx;
          dec_miss     = 1'b0;
        end
      end
    end
  end else begin : gen_offset_slice
    always_comb begin
      // Coordinates taken straight from the address, every address hits
      dec_dst.xy.x = addr_i[XAddrOffset +: MeshDimW];
      dec_dst.xy.y = addr_i[YAddrOffset +: MeshDimW];
      dec_miss     = 1'b0;
    end
  end

  // Control state, cleared on reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      miss_q  <= 1'b0;
    end else begin
      valid_q <= valid_i;
      // Miss only flagged for a real request
      miss_q  <= valid_i & dec_miss;
    end
  end

  // Payload, loaded with each request
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      addr_q <= addr_i;
      dst_q  <= dec_dst;
    end
  end

  assign out_o.valid  = valid_q;
  assign out_o.miss   = miss_q;
  assign out_o.addr   = addr_q;
  assign out_o.dst_id = dst_q;

endmodule

`default_nettype wire

//--- source/xy_route_compute.sv
// Execute stage xy_route_compute: dimension-ordered XY routing against local coordinates
`timescale 1ns/100ps
`default_nettype none

module xy_route_compute import noc_pkg::*; #(
  // Mesh position of this port
  parameter int LocalX = 1,
  parameter int LocalY = 2
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  noc_dec_if.dst   in_i,
  noc_route_if.src out_o
);

  localparam coord_t LocX = coord_t'(LocalX);
  localparam coord_t LocY = coord_t'(LocalY);

  route_dir_e next_dir;

  logic       valid_q;
  logic       miss_q;
  addr_t      addr_q;
  dst_id_u    dst_q;
  route_dir_e dir_q;

  // X first, then Y, local when both match
  always_comb begin
    if (in_i.dst_id.xy.x > LocX) begin
      next_dir = DirEast;
    end else if (in_i.dst_id.xy.x < LocX) begin
      next_dir = DirWest;
    end else if (in_i.dst_id.xy.y > LocY) begin
      next_dir = DirNorth;
    end else if (in_i.dst_id.xy.y < LocY) begin
      next_dir = DirSouth;
    end else begin
      next_dir = DirLocal;
    end
  end

  // Strobes
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      miss_q  <= 1'b0;
    end else begin
      valid_q <= in_i.valid;
      miss_q  <= in_i.valid & in_i.miss;
    end
  end

  // Forwarded fields and the chosen port
  always_ff @(posedge clk_i) begin
    if (in_i.valid) begin
      addr_q <= in_i.addr;
      dst_q  <= in_i.dst_id;
      dir_q  <= next_dir;
    end
  end

  assign out_o.valid  = valid_q;
  assign out_o.miss   = miss_q;
  assign out_o.addr   = addr_q;
  assign out_o.dst_id = dst_q;
  assign out_o.dir    = dir_q;

endmodule

`default_nettype wire

//--- source/hdr_assemble.sv
// Result stage hdr_assemble: header outputs, miss drop and saturating miss counter
`timescale 1ns/100ps
`default_nettype none

module hdr_assemble import noc_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  noc_route_if.dst           in_i,
  output logic               valid_o,
  output addr_t              addr_o,
  output coord_t             dst_x_o,
  output coord_t             dst_y_o,
  output route_dir_e         dir_o,
  output logic               miss_o,
  output logic [ErrCntW-1:0] miss_cnt_o
);

  logic [ErrCntW-1:0] miss_cnt_q;
  logic               cnt_full;

  // A miss replaces valid, never both
  assign valid_o = in_i.valid & ~in_i.miss;
  assign miss_o  = in_i.valid & in_i.miss;

  // Header fields pass straight through
  assign addr_o  = in_i.addr;
  assign dst_x_o = in_i.dst_id.xy.x;
  assign dst_y_o = in_i.dst_id.xy.y;
  assign dir_o   = in_i.dir;

  // Hold at all ones
  assign cnt_full = &miss_cnt_q;

  // Counts on the edge after the miss strobe
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      miss_cnt_q <= '0;
    end else if (miss_o && !cnt_full) begin
      miss_cnt_q <= miss_cnt_q + 1'b1;
    end
  end

  assign miss_cnt_o = miss_cnt_q;

endmodule

`default_nettype wire

//--- source/noc_ingress_top.sv
// Top level noc_ingress_top: decode, execute and result stages on plain ports
`timescale 1ns/100ps
`default_nettype none

module noc_ingress_top import noc_pkg::*; #(
  // Map search when set, offset slicing when clear
  parameter bit UseIdTable  = 1'b1,
  parameter int XAddrOffset = 12,
  parameter int YAddrOffset = 14,
  // Own position on the mesh
  parameter int LocalX      = 1,
  parameter int LocalY      = 2
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               valid_i,
  input  addr_t              addr_i,
  output logic               valid_o,
  output addr_t              addr_o,
  output coord_t             dst_x_o,
  output coord_t             dst_y_o,
  output route_dir_e         dir_o,
  output logic               miss_o,
  output logic [ErrCntW-1:0] miss_cnt_o
);

  // Stage links
  noc_dec_if   dec_bus ();
  noc_route_if route_bus ();

  // Address to destination, 1 cycle
  addr_translate #(
    .UseIdTable  (UseIdTable),
    .XAddrOffset (XAddrOffset),
    .YAddrOffset (YAddrOffset)
  ) i_addr_translate (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (valid_i),
    .addr_i  (addr_i),
    .out_o   (dec_bus)
  );

  // Output port choice, 1 cycle
  xy_route_compute #(
    .LocalX (LocalX),
    .LocalY (LocalY)
  ) i_xy_route_compute (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .in_i    (dec_bus),
    .out_o   (route_bus)
  );

  // Header and miss handling, no added latency
  hdr_assemble i_hdr_assemble (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .in_i       (route_bus),
    .valid_o    (valid_o),
    .addr_o     (addr_o),
    .dst_x_o    (dst_x_o),
    .dst_y_o    (dst_y_o),
    .dir_o      (dir_o),
    .miss_o     (miss_o),
    .miss_cnt_o (miss_cnt_o)
  );

endmodule

`default_nettype wire

//--- verif/noc_ingress_assertions.sv
// Bound checker of hdr_assemble: exclusive strobes, legal direction, non-decreasing counter
`timescale 1ns/100ps
`default_nettype none

module noc_ingress_assertions import noc_pkg::*; (
  input logic               clk_i,
  input logic               rst_n_i,
  input logic               valid_i,
  input logic               miss_i,
  input route_dir_e         dir_i,
  input logic [ErrCntW-1:0] miss_cnt_i
);

  // A request leaves as a header or as a miss, never both
  a_strobe_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(valid_i && miss_i))
    else $error("valid_o and miss_o high in the same cycle");

  // Only the five router ports
  a_dir_legal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_i |-> (dir_i inside {DirLocal, DirEast, DirWest, DirNorth, DirSouth}))
    else $error("dir_o carries an illegal direction code");

  // Saturating counter only moves up
  a_cnt_up: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    miss_cnt_i >= $past(miss_cnt_i))
    else $error("miss_cnt_o decreased");

endmodule

bind hdr_assemble noc_ingress_assertions i_assertions (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .valid_i    (valid_o),
  .miss_i     (miss_o),
  .dir_i      (dir_o),
  .miss_cnt_i (miss_cnt_o)
);

`default_nettype wire

//--- verif/tb_noc_ingress.sv
// Directed testbench for noc_ingress_top with map and offset instances, reference model, report
`timescale 1ns/100ps
`default_nettype none

module tb_noc_ingress import noc_pkg::*; ();

  localparam coord_t LocX      = 2'd1;
  localparam coord_t LocY      = 2'd2;
  localparam int     MaxLat    = 8;
  localparam int     NumStream = 40;
  // More misses than the counter can hold
  localparam int     NumSat    = 260;

  logic               clk;
  logic               rst_n;
  logic               req_valid;
  addr_t              req_addr;
  // Index 0 follows i_dut, index 1 follows i_dut_offset
  logic               valid_w [2];
  addr_t              addr_w [2];
  coord_t             x_w [2];
  coord_t             y_w [2];
  route_dir_e         dir_w [2];
  logic               miss_w [2];
  logic [ErrCntW-1:0] cnt_w [2];
  // Miss count expected by the model
  logic [ErrCntW-1:0] exp_cnt [2];
  logic [31:0]        rng;
  int                 test_errs;
  int                 total_errs;
  int                 n_tests;
  int                 n_ok;

  noc_ingress_top #(.UseIdTable(1'b1), .LocalX(LocX), .LocalY(LocY)) i_dut (
    .clk_i(clk), .rst_n_i(rst_n), .valid_i(req_valid), .addr_i(req_addr),
    .valid_o(valid_w[0]), .addr_o(addr_w[0]), .dst_x_o(x_w[0]), .dst_y_o(y_w[0]),
    .dir_o(dir_w[0]), .miss_o(miss_w[0]), .miss_cnt_o(cnt_w[0]));

  // Coordinates sliced from address bits 13:12 and 15:14
  noc_ingress_top #(.UseIdTable(1'b0), .LocalX(LocX), .LocalY(LocY)) i_dut_offset (
    .clk_i(clk), .rst_n_i(rst_n), .valid_i(req_valid), .addr_i(req_addr),
    .valid_o(valid_w[1]), .addr_o(addr_w[1]), .dst_x_o(x_w[1]), .dst_y_o(y_w[1]),
    .dir_o(dir_w[1]), .miss_o(miss_w[1]), .miss_cnt_o(cnt_w[1]));

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    return v ^ (v << 5);
  endfunction

  // Expected endpoint (y in 3:2, x in 1:0), miss flag and output port
  function automatic void ref_model(input bit use_map, input addr_t a, output logic [3:0] ep,
                                    output logic miss, output route_dir_e dir);
    ep   = {a[15:14], a[13:12]};
    miss = 1'b0;
    if (use_map) begin
      if (a < 32'h1000_0000) ep = 4'd5;
      else if (a < 32'h2000_0000) ep = 4'd10;
      else if (a >= 32'h4000_0000 && a < 32'h4010_0000) ep = 4'd0;
      else if (a >= 32'h8000_0000 && a < 32'hC000_0000) ep = 4'd15;
      else miss = 1'b1;
    end
    // X resolved before Y
    if (ep[1:0] > LocX) dir = DirEast;
    else if (ep[1:0] < LocX) dir = DirWest;
    else if (ep[3:2] > LocY) dir = DirNorth;
    else if (ep[3:2] < LocY) dir = DirSouth;
    else dir = DirLocal;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_quiet();
    for (int k = 0; k < 2; k++) begin
      string p;
      p = (k == 0) ? "i_dut" : "i_dut_offset";
      check_val({p, ".valid_o"}, 32'(valid_w[k]), 32'h0);
      check_val({p, ".miss_o"}, 32'(miss_w[k]), 32'h0);
    end
  endtask

  task automatic check_count();
    check_val("i_dut.miss_cnt_o", 32'(cnt_w[0]), 32'(exp_cnt[0]));
    check_val("i_dut_offset.miss_cnt_o", 32'(cnt_w[1]), 32'(exp_cnt[1]));
  endtask

  // Header or miss of one instance against the model
  task automatic check_outputs(input int k, input addr_t a);
    logic [3:0] ep;
    logic       miss;
    route_dir_e dir;
    string      p;
    ref_model(k == 0, a, ep, miss, dir);
    p = (k == 0) ? "i_dut" : "i_dut_offset";
    check_val({p, ".valid_o"}, 32'(valid_w[k]), 32'(!miss));
    check_val({p, ".miss_o"}, 32'(miss_w[k]), 32'(miss));
    if (!miss) begin
      check_val({p, ".addr_o"}, addr_w[k], a);
      check_val({p, ".dst_x_o"}, 32'(x_w[k]), 32'(ep[1:0]));
      check_val({p, ".dst_y_o"}, 32'(y_w[k]), 32'(ep[3:2]));
      check_val({p, ".dir_o"}, 32'(dir_w[k]), 32'(dir));
    end
  endtask

  // Counter model holds at all ones
  task automatic note_request(input addr_t a);
    logic [3:0] ep;
    logic       miss;
    route_dir_e dir;
    for (int k = 0; k < 2; k++) begin
      ref_model(k == 0, a, ep, miss, dir);
      if (miss && exp_cnt[k] != '1) exp_cnt[k]++;
    end
  endtask

  // Single strobe, bounded wait for the output, latency and field checks
  task automatic issue_and_check(input addr_t a, input bit chk_map, input bit chk_off);
    int lat;
    bit seen;
    req_valid = 1'b1;
    req_addr  = a;
    note_request(a);
    lat  = 0;
    seen = 1'b0;
    while (!seen && lat < MaxLat) begin
      @(negedge clk);
      seen = valid_w[0] | miss_w[0] | valid_w[1] | miss_w[1];
      if (!seen) begin
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        lat++;
      end
    end
    if (!seen) begin
      $display("no output strobe within %0d cycles for address 0x%08h", MaxLat, a);
      test_errs++;
    end else begin
      check_val("latency", lat, 2);
      if (chk_map) check_outputs(0, a);
      if (chk_off) check_outputs(1, a);
    end
    // Counter has taken the miss by the next edge
    @(posedge clk);
    #1;
    check_count();
  endtask

  task automatic finish_test(input string name);
    n_tests++;
    if (test_errs == 0) begin
      n_ok++;
      $display("%-14s ok", name);
    end else begin
      $display("%-14s %0d errors", name, test_errs);
    end
    total_errs += test_errs;
    test_errs = 0;
  endtask

  task automatic test_reset();
    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      #1;
      if (i == 3) rst_n = 1'b1;
      check_quiet();
      check_count();
    end
    // Idle cycles after release
    for (int i = 0; i < 3; i++) begin
      @(negedge clk);
      check_quiet();
      check_count();
    end
    @(posedge clk);
    #1;
    finish_test("reset");
  endtask

  task automatic test_map();
    // One address per rule, rule 2 at both edges
    addr_t addrs [6] = '{32'h0123_4567, 32'h1FFF_FFFC, 32'h4000_0000,
                         32'h400F_FFFF, 32'h9876_5432, 32'hBFFF_FFFF};
    foreach (addrs[i]) issue_and_check(addrs[i], 1'b1, 1'b0);
    finish_test("map_translate");
  endtask

  task automatic test_offset();
    for (int e = 0; e < 16; e++) issue_and_check({16'hC35A, 4'(e), 12'hA5C}, 1'b0, 1'b1);
    finish_test("offset_xlate");
  endtask

  task automatic test_routing();
    // Endpoints y*4+x around (1,2) for Local, East, East, West, West, North, South, South
    logic [3:0] eps [8] = '{4'd9, 4'd2, 4'd15, 4'd8, 4'd12, 4'd13, 4'd1, 4'd5};
    foreach (eps[i]) issue_and_check({16'h2468, eps[i], 12'h000}, 1'b0, 1'b1);
    finish_test("xy_routing");
  endtask

  task automatic test_miss();
    addr_t addrs [5] = '{32'h2000_0000, 32'hC000_0000, 32'h3FFF_FFFF,
                         32'h4010_0000, 32'hFFFF_FFFF};
    foreach (addrs[i]) issue_and_check(addrs[i], 1'b1, 1'b1);
    finish_test("map_miss");
  endtask

  // Back-to-back strobes, results popped in order two cycles later
  task automatic test_stream();
    addr_t q_addr [$];
    int    q_cyc [$];
    for (int c = 0; c < NumStream + 3; c++) begin
      req_valid = (c < NumStream);
      if (c < NumStream) begin
        rng      = xorshift32(rng);
        req_addr = rng;
        note_request(rng);
        q_addr.push_back(rng);
        q_cyc.push_back(c);
      end
      @(negedge clk);
      if (q_cyc.size() > 0 && q_cyc[0] == c - 2) begin
        check_outputs(0, q_addr[0]);
        check_outputs(1, q_addr[0]);
        void'(q_addr.pop_front());
        void'(q_cyc.pop_front());
      end else begin
        check_quiet();
      end
      @(posedge clk);
      #1;
    end
    check_val("results left in queue", q_cyc.size(), 0);
    check_count();
    finish_test("stream");
  endtask

  // Back-to-back misses on i_dut until the counter sits at its limit
  task automatic test_saturate();
    for (int c = 0; c < NumSat; c++) begin
      req_valid = 1'b1;
      req_addr  = 32'h2000_0000;
      note_request(32'h2000_0000);
      @(posedge clk);
      #1;
    end
    req_valid = 1'b0;
    // Two pipeline cycles, then the counter edge
    repeat (3) @(posedge clk);
    #1;
    check_count();
    finish_test("saturate");
  endtask

  initial begin
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req_addr   = '0;
    rng        = 32'h8ce7_9bf4;
    exp_cnt    = '{default: '0};
    test_errs  = 0;
    total_errs = 0;
    n_tests    = 0;
    n_ok       = 0;
    test_reset();
    test_map();
    test_offset();
    test_routing();
    test_miss();
    test_stream();
    test_saturate();
    $display("%0d of %0d tests clean, %0d errors", n_ok, n_tests, total_errs);
    if (total_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
source/noc_pkg.sv
source/noc_stage_if.sv
source/addr_translate.sv
source/xy_route_compute.sv
source/hdr_assemble.sv
source/noc_ingress_top.sv
verif/noc_ingress_assertions.sv
verif/tb_noc_ingress.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_noc_ingress
FILELIST  := sim.f
VFLAGS    := --binary --timing --assert -Wno-fatal
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

SHELL       := /bin/bash
.SHELLFLAGS := -o pipefail -c

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation reported failure"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
